// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = spi_tx_engine_tb
FILELIST = src.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir

// File: src.f
src/spi_tx_pkg.sv
src/spi_lane_config.sv
src/spi_data_assemble.sv
src/spi_sdo_shiftreg.sv
src/spi_tx_engine.sv
test/spi_tx_engine_properties.sv
test/spi_tx_engine_tb.sv

// File: src/spi_data_assemble.sv
`timescale 1ns/1ps

module spi_data_assemble #(
    parameter int NUM_OF_SDO = 4,
    parameter int DATA_WIDTH = 8
) (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic [DATA_WIDTH-1:0]                   data,
    input  logic                                    data_valid,
    input  spi_tx_pkg::lane_cfg_t                   lane_cfg,
    input  spi_tx_pkg::lane_idx_t [NUM_OF_SDO-1:0]  active_idx,
    input  logic                                    cfg_busy,
    input  spi_tx_pkg::word_len_t                   word_length,
    input  logic                                    idle_state,
    input  logic                                    shift_busy,
    output logic                                    data_ready,
    output logic [NUM_OF_SDO*DATA_WIDTH-1:0]        frame,
    output logic                                    frame_load
);
    import spi_tx_pkg::*;

    localparam int SEL_W = (NUM_OF_SDO > 1) ? $clog2(NUM_OF_SDO) : 1;

    lane_cnt_t                        word_cnt;
    lane_idx_t                        lane_sel;
    logic                             accept;
    logic                             last_word;
    logic                             frame_full;
    logic                             sr_busy;
    logic [DATA_WIDTH-1:0]            aligned;
    logic [NUM_OF_SDO*DATA_WIDTH-1:0] frame_next;

    // a complete frame waiting for the shift register blocks new words,
    // and an empty mask never needs any
    // no word is taken while reset is held
    assign data_ready = resetn && !cfg_busy && !frame_full && (lane_cfg.num_active != '0);
    assign accept     = data_valid && data_ready;
    assign last_word  = (word_cnt == lane_cfg.num_active - 1'b1);

    // a load issued last cycle has not reached the shift register yet
    assign sr_busy = shift_busy || frame_load;

    // with every lane active the word counter is the lane number itself
    assign lane_sel = lane_cfg.all_active ? lane_idx_t'(word_cnt)
                                          : active_idx[word_cnt[SEL_W-1:0]];

    // MSB of the programmed word length lands on the MSB of the slot
    assign aligned = data << (DATA_WIDTH - int'(word_length));

    // the first word of a frame starts from an all idle frame
    always_comb begin
        frame_next = (word_cnt == '0) ? {(NUM_OF_SDO*DATA_WIDTH){idle_state}} : frame;
        frame_next[lane_sel*DATA_WIDTH +: DATA_WIDTH] = aligned;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            frame <= frame_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            word_cnt   <= '0;
            frame_full <= 1'b0;
            frame_load <= 1'b0;
        end else begin
            frame_load <= 1'b0;
            // a new lane configuration always starts a fresh frame
            if (cfg_busy) begin
                word_cnt <= '0;
            end else if (accept) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
            if (accept && last_word) begin
                if (sr_busy) begin
                    frame_full <= 1'b1;
                end else begin
                    frame_load <= 1'b1;
                end
            end else if (frame_full && !sr_busy) begin
                frame_full <= 1'b0;
                frame_load <= 1'b1;
            end
        end
    end

endmodule

// File: src/spi_lane_config.sv
`timescale 1ns/1ps

module spi_lane_config #(
    parameter int NUM_OF_SDO = 4
) (
    input  logic                                     clk,
    input  logic                                     resetn,
    input  logic                                     lane_cmd,
    input  spi_tx_pkg::lane_mask_t                   lane_cmd_mask,
    output spi_tx_pkg::lane_cfg_t                    lane_cfg,
    output spi_tx_pkg::lane_idx_t [NUM_OF_SDO-1:0]   active_idx,
    output logic                                     cfg_busy
);
    import spi_tx_pkg::*;

    // lanes that physically exist in this instance
    localparam lane_mask_t ALL_LANES = lane_mask_t'((1 << NUM_OF_SDO) - 1);

    lane_cnt_t cmd_count;
    lane_idx_t scan_pos;
    lane_idx_t wr_pos;

    // only lanes below NUM_OF_SDO take part in the count
    always_comb begin
        cmd_count = '0;
        for (int i = 0; i < NUM_OF_SDO; i++) begin
            cmd_count = cmd_count + lane_cnt_t'(lane_cmd_mask[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lane_cfg.num_active <= lane_cnt_t'(NUM_OF_SDO);
            lane_cfg.all_active <= 1'b1;
            lane_cfg.mask       <= ALL_LANES;
            scan_pos            <= '0;
            wr_pos              <= '0;
            cfg_busy            <= 1'b0;
        end else if (lane_cmd) begin
            lane_cfg.num_active <= cmd_count;
            lane_cfg.all_active <= (lane_cmd_mask & ALL_LANES) == ALL_LANES;
            lane_cfg.mask       <= lane_cmd_mask;
            scan_pos            <= '0;
            wr_pos              <= '0;
            cfg_busy            <= 1'b1;
        end else if (cfg_busy) begin
            // one mask bit per cycle, active lanes are packed into the list in order
            scan_pos <= scan_pos + 1'b1;
            if (lane_cfg.mask[scan_pos]) begin
                wr_pos <= wr_pos + 1'b1;
            end
            if (scan_pos == lane_idx_t'(NUM_OF_SDO - 1)) begin
                cfg_busy <= 1'b0;
            end
        end
    end

    // entry k ends up naming the k-th active lane
    always_ff @(posedge clk) begin
        if (cfg_busy && !lane_cmd && lane_cfg.mask[scan_pos]) begin
            active_idx[wr_pos] <= scan_pos;
        end
    end

endmodule

// File: src/spi_sdo_shiftreg.sv
`timescale 1ns/1ps

module spi_sdo_shiftreg #(
    parameter int NUM_OF_SDO = 4,
    parameter int DATA_WIDTH = 8
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic [NUM_OF_SDO*DATA_WIDTH-1:0] frame,
    input  logic                             frame_load,
    input  spi_tx_pkg::word_len_t            word_length,
    input  logic                             idle_state,
    output logic [NUM_OF_SDO-1:0]            sdo,
    output logic                             sdo_active,
    output logic                             shift_busy,
    output logic                             frame_done
);
    import spi_tx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SHIFT
    } state_t;

    state_t                state;
    word_len_t             bit_cnt;
    logic [DATA_WIDTH-1:0] lane_sr [NUM_OF_SDO];

    assign shift_busy = (state != ST_IDLE);
    assign sdo_active = (state == ST_SHIFT);

    // each lane drives its current MSB only while a frame is on the wire
    always_comb begin
        for (int k = 0; k < NUM_OF_SDO; k++) begin
            sdo[k] = sdo_active ? lane_sr[k][DATA_WIDTH-1] : idle_state;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (frame_load) begin
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    bit_cnt <= '0;
                    state   <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    if (bit_cnt == word_length - 1'b1) begin
                        state      <= ST_IDLE;
                        frame_done <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // all lanes move together, the vacated LSBs take the idle level
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_OF_SDO; k++) begin
            if (state == ST_IDLE && frame_load) begin
                lane_sr[k] <= frame[k*DATA_WIDTH +: DATA_WIDTH];
            end else if (state == ST_SHIFT) begin
                lane_sr[k] <= {lane_sr[k][DATA_WIDTH-2:0], idle_state};
            end
        end
    end

endmodule

// File: src/spi_tx_engine.sv
`timescale 1ns/1ps

module spi_tx_engine #(
    parameter int NUM_OF_SDO = 4,
    parameter int DATA_WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   lane_cmd,
    input  spi_tx_pkg::lane_mask_t lane_cmd_mask,
    input  spi_tx_pkg::word_len_t  word_length,
    input  logic                   idle_state,
    input  logic [DATA_WIDTH-1:0]  data,
    input  logic                   data_valid,
    output logic                   data_ready,
    output logic [NUM_OF_SDO-1:0]  sdo,
    output logic                   sdo_active,
    output logic                   frame_done
);
    import spi_tx_pkg::*;

    lane_cfg_t                        lane_cfg;
    lane_idx_t [NUM_OF_SDO-1:0]       active_idx;
    logic                             cfg_busy;
    logic [NUM_OF_SDO*DATA_WIDTH-1:0] frame;
    logic                             frame_load;
    logic                             shift_busy;

    spi_lane_config #(
        .NUM_OF_SDO (NUM_OF_SDO)
    ) spi_lane_config_i (
        .clk           (clk),
        .resetn        (resetn),
        .lane_cmd      (lane_cmd),
        .lane_cmd_mask (lane_cmd_mask),
        .lane_cfg      (lane_cfg),
        .active_idx    (active_idx),
        .cfg_busy      (cfg_busy)
    );

    // assembler gates data_ready with cfg_busy and the shift register state
    spi_data_assemble #(
        .NUM_OF_SDO (NUM_OF_SDO),
        .DATA_WIDTH (DATA_WIDTH)
    ) spi_data_assemble_i (
        .clk         (clk),
        .resetn      (resetn),
        .data        (data),
        .data_valid  (data_valid),
        .lane_cfg    (lane_cfg),
        .active_idx  (active_idx),
        .cfg_busy    (cfg_busy),
        .word_length (word_length),
        .idle_state  (idle_state),
        .shift_busy  (shift_busy),
        .data_ready  (data_ready),
        .frame       (frame),
        .frame_load  (frame_load)
    );

    spi_sdo_shiftreg #(
        .NUM_OF_SDO (NUM_OF_SDO),
        .DATA_WIDTH (DATA_WIDTH)
    ) spi_sdo_shiftreg_i (
        .clk         (clk),
        .resetn      (resetn),
        .frame       (frame),
        .frame_load  (frame_load),
        .word_length (word_length),
        .idle_state  (idle_state),
        .sdo         (sdo),
        .sdo_active  (sdo_active),
        .shift_busy  (shift_busy),
        .frame_done  (frame_done)
    );

endmodule

// File: src/spi_tx_pkg.sv
package spi_tx_pkg;

    // widest lane count the engine is built for, one mask bit per SDO lane
    localparam int MAX_SDO = 8;

    // largest word length any instance may be configured with
    localparam int MAX_DATA_WIDTH = 32;

    // word_length runs from 1 to DATA_WIDTH, so it needs room for the full count
    localparam int WORD_LEN_W = $clog2(MAX_DATA_WIDTH + 1);

    // lane counts run from 0 to MAX_SDO inclusive
    localparam int LANE_CNT_W = $clog2(MAX_SDO + 1);

    localparam int LANE_IDX_W = $clog2(MAX_SDO);

    typedef logic [MAX_SDO-1:0] lane_mask_t;

    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    typedef logic [LANE_CNT_W-1:0] lane_cnt_t;

    typedef logic [WORD_LEN_W-1:0] word_len_t;

    // summary of the current lane configuration as seen by the assembler
    typedef struct packed {
        lane_cnt_t  num_active;
        logic       all_active;
        lane_mask_t mask;
    } lane_cfg_t;

endpackage

// File: test/spi_tx_engine_properties.sv
`timescale 1ns/1ps

module spi_tx_engine_properties #(
    parameter int NUM_OF_SDO = 4
) (
    input logic                  clk,
    input logic                  resetn,
    input logic                  sdo_active,
    input logic                  data_ready,
    input logic                  frame_done,
    input logic                  idle_state,
    input logic [NUM_OF_SDO-1:0] sdo
);

    // once reset has been held for a cycle, nothing may be offered or shifted
    reset_quiet: assert property (@(posedge clk)
        !resetn ##1 !resetn |-> !sdo_active && !data_ready)
        else $error("sdo_active or data_ready high during reset");

    // the last bit of a frame is followed by its done pulse
    done_after_frame: assert property (@(posedge clk) disable iff (!resetn)
        $fell(sdo_active) |-> frame_done)
        else $error("frame_done missing after end of frame");

    idle_between_frames: assert property (@(posedge clk) disable iff (!resetn)
        !sdo_active |-> sdo == {NUM_OF_SDO{idle_state}})
        else $error("sdo not at idle level outside a frame");

endmodule

bind spi_tx_engine spi_tx_engine_properties #(
    .NUM_OF_SDO (NUM_OF_SDO)
) spi_tx_engine_properties_i (
    .clk        (clk),
    .resetn     (resetn),
    .sdo_active (sdo_active),
    .data_ready (data_ready),
    .frame_done (frame_done),
    .idle_state (idle_state),
    .sdo        (sdo)
);

// File: test/spi_tx_engine_tb.sv
`timescale 1ns/1ps

module spi_tx_engine_tb;
    import spi_tx_pkg::*;

    localparam int NUM_OF_SDO = 4;
    localparam int DATA_WIDTH = 8;
    localparam int MAX_REC    = 32;
    localparam int CLK_PERIOD = 20;

    logic                  clk;
    logic                  resetn;
    logic                  lane_cmd;
    lane_mask_t            lane_cmd_mask;
    word_len_t             word_length;
    logic                  idle_state;
    logic [DATA_WIDTH-1:0] data;
    logic                  data_valid;
    logic                  data_ready;
    logic [NUM_OF_SDO-1:0] sdo;
    logic                  sdo_active;
    logic                  frame_done;

    string                 rec_name [MAX_REC];
    logic [7:0]            rec_mask [MAX_REC];
    int                    rec_len  [MAX_REC];
    int                    rec_idle [MAX_REC];
    int                    rec_gap  [MAX_REC];
    logic [DATA_WIDTH-1:0] rec_word [MAX_REC][NUM_OF_SDO];
    int                    n_rec;
    logic                  stim_loaded;

    // expected sdo vector for each shift cycle and the test it belongs to
    logic [NUM_OF_SDO-1:0] exp_bits [$];
    string                 exp_name [$];

    int     errors;
    int     checks;
    int     frames_sent;
    int     frames_done;
    integer seed;

    spi_tx_engine #(
        .NUM_OF_SDO (NUM_OF_SDO),
        .DATA_WIDTH (DATA_WIDTH)
    ) spi_tx_engine_i (
        .clk           (clk),
        .resetn        (resetn),
        .lane_cmd      (lane_cmd),
        .lane_cmd_mask (lane_cmd_mask),
        .word_length   (word_length),
        .idle_state    (idle_state),
        .data          (data),
        .data_valid    (data_valid),
        .data_ready    (data_ready),
        .sdo           (sdo),
        .sdo_active    (sdo_active),
        .frame_done    (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic read_records();
        int    fd;
        int    cnt;
        string line;
        string nm;
        int    m;
        int    l;
        int    i;
        int    g;
        int    w0;
        int    w1;
        int    w2;
        int    w3;
        fd = $fopen("test/spi_tx_stim.txt", "r");
        if (fd == 0) begin
            $display("stimulus file test/spi_tx_stim.txt could not be opened");
        end else begin
            while (!$feof(fd) && n_rec < MAX_REC) begin
                cnt = $fgets(line, fd);
                if (cnt > 1 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %h %d %d %d %h %h %h %h",
                                  nm, m, l, i, g, w0, w1, w2, w3);
                    if (cnt == 9) begin
                        rec_name[n_rec]    = nm;
                        rec_mask[n_rec]    = m[7:0];
                        rec_len[n_rec]     = l;
                        rec_idle[n_rec]    = i;
                        rec_gap[n_rec]     = g;
                        rec_word[n_rec][0] = w0[7:0];
                        rec_word[n_rec][1] = w1[7:0];
                        rec_word[n_rec][2] = w2[7:0];
                        rec_word[n_rec][3] = w3[7:0];
                        n_rec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // wait until every expected bit has been shifted out
    task automatic wait_drain();
        while (exp_bits.size() != 0 || sdo_active) begin
            @(negedge clk);
        end
    endtask

    // hold the word until the engine takes it on a rising edge
    task automatic send_word(input logic [DATA_WIDTH-1:0] w);
        data       = w;
        data_valid = 1'b1;
        while (!data_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        data_valid = 1'b0;
    endtask

    task automatic run_record(input int r);
        int                    k;
        int                    j;
        int                    b;
        logic [NUM_OF_SDO-1:0] e;
        logic [DATA_WIDTH-1:0] lane_word [NUM_OF_SDO];
        // word length and idle level must stay put while a frame shifts
        if (int'(word_length) != rec_len[r] || int'(idle_state) != rec_idle[r]) begin
            wait_drain();
            word_length = word_len_t'(rec_len[r]);
            idle_state  = rec_idle[r][0];
        end
        lane_cmd      = 1'b1;
        lane_cmd_mask = rec_mask[r];
        @(negedge clk);
        lane_cmd = 1'b0;
        j = 0;
        for (k = 0; k < NUM_OF_SDO; k++) begin
            lane_word[k] = '0;
            if (rec_mask[r][k]) begin
                lane_word[k] = rec_word[r][j];
                j++;
            end
        end
        for (k = 0; k < j; k++) begin
            if (rec_gap[r] != 0) begin
                repeat ($random(seed) & 3) @(negedge clk);
            end
            send_word(rec_word[r][k]);
        end
        // low word_length bits of each active lane go out MSB first
        for (b = 0; b < rec_len[r]; b++) begin
            for (k = 0; k < NUM_OF_SDO; k++) begin
                e[k] = rec_mask[r][k] ? lane_word[k][rec_len[r] - 1 - b] : rec_idle[r][0];
            end
            exp_bits.push_back(e);
            exp_name.push_back(rec_name[r]);
        end
        frames_sent++;
    endtask

    always @(negedge clk) begin
        if (resetn && frame_done) begin
            frames_done++;
        end
        if (resetn && sdo_active) begin
            if (exp_bits.size() == 0) begin
                errors++;
                $display("sdo_active was high while no frame bits were expected");
            end else begin
                checks++;
                if (sdo !== exp_bits[0]) begin
                    errors++;
                    $display("Error: test %s expected sdo %b actual %b",
                             exp_name[0], exp_bits[0], sdo);
                end
                void'(exp_bits.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    initial begin
        wait (stim_loaded);
        #((n_rec * 200 + 16) * CLK_PERIOD);
        $display("run stopped by the watchdog, the engine did not finish the tests in time");
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        resetn        = 1'b0;
        lane_cmd      = 1'b0;
        lane_cmd_mask = '0;
        word_length   = word_len_t'(DATA_WIDTH);
        idle_state    = 1'b0;
        data          = '0;
        data_valid    = 1'b0;
        errors        = 0;
        checks        = 0;
        frames_sent   = 0;
        frames_done   = 0;
        n_rec         = 0;
        stim_loaded   = 1'b0;
        seed          = 32'hecc43303;
        read_records();
        if (n_rec == 0) begin
            $display("no test records were found in the stimulus file");
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("TEST FAILED");
            $finish;
        end else begin
            stim_loaded = 1'b1;
            repeat (16) @(negedge clk);
            resetn = 1'b1;
            @(negedge clk);
            for (int r = 0; r < n_rec; r++) begin
                run_record(r);
            end
            wait_drain();
            repeat (4) @(negedge clk);
            if (frames_done != frames_sent) begin
                errors++;
                $display("Error: test all expected frame_done count %0d actual %0d",
                         frames_sent, frames_done);
            end
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

// File: test/spi_tx_stim.txt
# name mask(hex) word_length idle_state gap d0 d1 d2 d3
# data words are hex, one per active lane in rising lane order, unused columns are 00
all_full      f 8 0 0 a5 3c 96 0f
partial_0101  5 8 0 0 c3 5a 00 00
short_len     f 3 0 0 05 02 07 01
idle_high     6 8 1 0 81 7e 00 00
bp_a          f 8 0 0 11 22 33 44
bp_b          f 8 0 0 55 66 77 88
bp_c          f 8 0 0 9a bc de f0
bp_gap_a      f 8 0 1 99 aa bb cc
bp_gap_b      f 8 0 1 dd ee ff 01
bp_gap_c      f 8 0 1 13 57 9b df
reconf_a      3 8 0 1 12 34 00 00
reconf_b      c 8 0 0 56 78 00 00
reconf_c      9 8 0 1 e7 18 00 00
single        8 5 1 1 1f 00 00 00
short_part    a 4 1 0 0c 03 00 00
short_gap     7 2 0 1 02 01 03 00
